// ==== Bender.yml ====
package:
  name: lsu_dcache

export_include_dirs:
  - .

sources:
  - files:
      - lsuPkg.sv
      - reqQueue.sv
      - cacheTagTable.sv
      - cacheDataArray.sv
      - lsuPipeline.sv
      - missFlushCtrl.sv
      - lsuTop.sv
  - target: test
    files:
      - memModel.sv
      - lsuTb.sv

// ==== cacheDataArray.sv ====
// word storage of both ways, byte-masked writes with write-first read forwarding
`include "lsu_macros.svh"

module cacheDataArray
    import lsuPkg::*;
(
    input  logic                                  clk,
    input  logic [`LSU_WIDX_W-1:0]                rdAddrA,
    output logic [`LSU_WAYS-1:0][`LSU_DATA_W-1:0] rdDataA,
    input  logic [`LSU_WIDX_W-1:0]                rdAddrB,
    output logic [`LSU_WAYS-1:0][`LSU_DATA_W-1:0] rdDataB,
    input  dataWrite_t                            pipeWr,
    input  dataWrite_t                            ctrlWr
);

    logic [`LSU_DATA_W-1:0] mem [`LSU_SETS * `LSU_LINE_WORDS][`LSU_WAYS];

    function automatic logic [`LSU_DATA_W-1:0] mergeBytes(input logic [`LSU_DATA_W-1:0] old,
                                                          input dataWrite_t wr);
        logic [`LSU_DATA_W-1:0] word;
        word = old;
        for (int b = 0; b < `LSU_MASK_W; b++) begin
            if (wr.mask[b]) begin
                word[8*b +: 8] = wr.data[8*b +: 8];
            end
        end
        return word;
    endfunction

    function automatic logic [`LSU_DATA_W-1:0] readWord(input logic [`LSU_WIDX_W-1:0] addr,
                                                        input int w);
        logic [`LSU_DATA_W-1:0] word;
        word = mem[addr][w];
        if (pipeWr.valid && pipeWr.idx == addr && pipeWr.way == w) begin
            word = mergeBytes(word, pipeWr);
        end
        if (ctrlWr.valid && ctrlWr.idx == addr && ctrlWr.way == w) begin
            word = mergeBytes(word, ctrlWr);
        end
        return word;
    endfunction

    always_ff @(posedge clk) begin
        if (pipeWr.valid) begin
            mem[pipeWr.idx][pipeWr.way] <= mergeBytes(mem[pipeWr.idx][pipeWr.way], pipeWr);
        end
        if (ctrlWr.valid) begin
            mem[ctrlWr.idx][ctrlWr.way] <= mergeBytes(mem[ctrlWr.idx][ctrlWr.way], ctrlWr);
        end
        for (int w = 0; w < `LSU_WAYS; w++) begin
            rdDataA[w] <= readWord(rdAddrA, w);
            rdDataB[w] <= readWord(rdAddrB, w);
        end
    end

    // store hits and fills never overlap
    assert property (@(posedge clk) !(pipeWr.valid === 1'b1 && ctrlWr.valid === 1'b1));

endmodule

// ==== cacheTagTable.sv ====
// tag, valid and dirty storage per set and way with two read and two write ports
`include "lsu_macros.svh"

module cacheTagTable
    import lsuPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`LSU_IDX_W-1:0] rdIdxA,
    output tagSet_t               rdSetA,
    input  logic [`LSU_IDX_W-1:0] rdIdxB,
    output tagSet_t               rdSetB,
    input  tagWrite_t             pipeWr,
    input  tagWrite_t             ctrlWr
);

    tagEntry_t tagMem [`LSU_SETS][`LSU_WAYS];

    // a write in the same cycle wins over the stored entry
    function automatic tagEntry_t readEntry(input logic [`LSU_IDX_W-1:0] idx, input int w);
        tagEntry_t e;
        e = tagMem[idx][w];
        if (pipeWr.valid && pipeWr.set == idx && pipeWr.way == w) begin
            e = pipeWr.entry;
        end
        if (ctrlWr.valid && ctrlWr.set == idx && ctrlWr.way == w) begin
            e = ctrlWr.entry;
        end
        return e;
    endfunction

    always_ff @(posedge clk) begin
        if (pipeWr.valid) begin
            tagMem[pipeWr.set][pipeWr.way] <= pipeWr.entry;
        end
        if (ctrlWr.valid) begin
            tagMem[ctrlWr.set][ctrlWr.way] <= ctrlWr.entry;
        end
        for (int w = 0; w < `LSU_WAYS; w++) begin
            rdSetA.way[w] <= readEntry(rdIdxA, w);
            rdSetB.way[w] <= readEntry(rdIdxB, w);
        end
    end

    // pipeline and controller take turns on the table
    assert property (@(posedge clk) disable iff (rst)
        !(pipeWr.valid && ctrlWr.valid));

endmodule

// ==== compile.f ====
+incdir+.
lsuPkg.sv
reqQueue.sv
cacheTagTable.sv
cacheDataArray.sv
lsuPipeline.sv
missFlushCtrl.sv
lsuTop.sv
memModel.sv
lsuTb.sv

// ==== lsuPipeline.sv ====
// two-stage lookup pipeline: array read, hit check, load results, store writes and misses
`include "lsu_macros.svh"

module lsuPipeline
    import lsuPkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst,
    input  lsuReq_t                               inReq,
    output logic                                  pop,
    input  logic                                  hold,
    output logic [`LSU_IDX_W-1:0]                 tagRdIdx,
    input  tagSet_t                               tagSet,
    output tagWrite_t                             tagWr,
    output logic [`LSU_WIDX_W-1:0]                dataRdAddr,
    input  logic [`LSU_WAYS-1:0][`LSU_DATA_W-1:0] dataRdData,
    output dataWrite_t                            dataWr,
    output missReq_t                              miss,
    input  logic                                  missDone,
    output logic                                  idle,
    output lsuRes_t                               res
);

    lsuReq_t s0;
    lsuReq_t s1;
    missReq_t missQ;
    logic [`LSU_WAY_W-1:0] rrWay;
    logic [`LSU_WAY_W-1:0] hitWay;
    logic [`LSU_WAY_W-1:0] victimWay;
    logic [`LSU_TAG_W-1:0] s1Tag;
    logic [`LSU_IDX_W-1:0] s1Set;
    logic hit;
    logic victimFound;
    logic s1Done;
    logic s1Free;
    logic s0Move;

    assign s1Tag = s1.addr[`LSU_ADDR_W-1 -: `LSU_TAG_W];
    assign s1Set = s1.addr[`LSU_OFF_W +: `LSU_IDX_W];

    // hit search and victim choice, first invalid way before round robin
    always_comb begin
        hit = 1'b0;
        hitWay = '0;
        victimFound = 1'b0;
        victimWay = rrWay;
        for (int w = 0; w < `LSU_WAYS; w++) begin
            if (tagSet.way[w].valid && tagSet.way[w].tag == s1Tag) begin
                hit = 1'b1;
                hitWay = w[`LSU_WAY_W-1:0];
            end
            if (!tagSet.way[w].valid && !victimFound) begin
                victimFound = 1'b1;
                victimWay = w[`LSU_WAY_W-1:0];
            end
        end
    end

    // stage 1 data is stale while a miss is pending
    assign s1Done = s1.valid && !missQ.valid && hit;
    assign s1Free = !s1.valid || s1Done;
    assign s0Move = s0.valid && s1Free;
    assign pop = inReq.valid && !hold && (!s0.valid || s1Free);

    // replay re-reads the missed entry in the missDone cycle
    assign dataRdAddr = missDone ? s1.addr[`LSU_WIDX_W-1:0] : s0.addr[`LSU_WIDX_W-1:0];
    assign tagRdIdx = dataRdAddr[`LSU_WIDX_W-1 -: `LSU_IDX_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            s0.valid <= 1'b0;
            s1.valid <= 1'b0;
            missQ.valid <= 1'b0;
            rrWay <= '0;
        end else begin
            if (pop) begin
                s0 <= inReq;
            end else if (s0Move) begin
                s0.valid <= 1'b0;
            end
            if (s0Move) begin
                s1 <= s0;
            end else if (s1Done) begin
                s1.valid <= 1'b0;
            end
            if (missDone) begin
                missQ.valid <= 1'b0;
            end else if (s1.valid && !missQ.valid && !hit) begin
                missQ <= '{valid: 1'b1, set: s1Set, way: victimWay, newTag: s1Tag,
                           victimTag: tagSet.way[victimWay].tag,
                           victimDirty: tagSet.way[victimWay].valid && tagSet.way[victimWay].dirty};
                if (!victimFound) begin
                    rrWay <= rrWay + 1'b1;
                end
            end
        end
    end

    always_comb begin
        res.valid = s1Done && (s1.op == opLoad);
        res.id = s1.id;
        res.data = dataRdData[hitWay];

        // store hit writes the word and marks the line dirty
        tagWr.valid = s1Done && (s1.op == opStore);
        tagWr.set = s1Set;
        tagWr.way = hitWay;
        tagWr.entry = '{valid: 1'b1, dirty: 1'b1, tag: s1Tag};

        dataWr.valid = tagWr.valid;
        dataWr.way = hitWay;
        dataWr.idx = s1.addr[`LSU_WIDX_W-1:0];
        dataWr.data = s1.data;
        dataWr.mask = s1.mask;
    end

    assign miss = missQ;
    assign idle = !s0.valid && !s1.valid;

    // the refilled line must hit on replay
    assert property (@(posedge clk) disable iff (rst)
        missDone |-> miss.valid ##1 s1Done);

endmodule

// ==== lsuPkg.sv ====
// shared types of the load/store unit: requests, results, tag and data writes, memory bus
`include "lsu_macros.svh"

package lsuPkg;

    typedef enum logic {
        opLoad,
        opStore
    } lsuOp_e;

    typedef enum logic [2:0] {
        stInit,
        stIdle,
        stWriteback,
        stFillReq,
        stFill,
        stFlushScan,
        stFlushWb
    } ctrlState_e;

    typedef enum logic [1:0] {
        memNone,
        memFill,
        memWriteback
    } memCmd_e;

    typedef struct packed {
        logic                   valid;
        lsuOp_e                 op;
        logic [`LSU_ID_W-1:0]   id;
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_DATA_W-1:0] data;
        logic [`LSU_MASK_W-1:0] mask;
    } lsuReq_t;

    typedef struct packed {
        logic                   valid;
        logic [`LSU_ID_W-1:0]   id;
        logic [`LSU_DATA_W-1:0] data;
    } lsuRes_t;

    // line address is {tag, set}
    typedef struct packed {
        memCmd_e                cmd;
        logic [`LSU_LINE_W-1:0] lineAddr;
        logic                   wvalid;
        logic [`LSU_DATA_W-1:0] wdata;
    } memReq_t;

    typedef struct packed {
        logic                   rvalid;
        logic [`LSU_DATA_W-1:0] rdata;
    } memRes_t;

    typedef struct packed {
        logic                  valid;
        logic                  dirty;
        logic [`LSU_TAG_W-1:0] tag;
    } tagEntry_t;

    typedef struct packed {
        tagEntry_t [`LSU_WAYS-1:0] way;
    } tagSet_t;

    typedef struct packed {
        logic                  valid;
        logic [`LSU_IDX_W-1:0] set;
        logic [`LSU_WAY_W-1:0] way;
        tagEntry_t             entry;
    } tagWrite_t;

    // idx is {set, word offset}
    typedef struct packed {
        logic                   valid;
        logic [`LSU_WAY_W-1:0]  way;
        logic [`LSU_WIDX_W-1:0] idx;
        logic [`LSU_DATA_W-1:0] data;
        logic [`LSU_MASK_W-1:0] mask;
    } dataWrite_t;

    typedef struct packed {
        logic                  valid;
        logic [`LSU_IDX_W-1:0] set;
        logic [`LSU_WAY_W-1:0] way;
        logic [`LSU_TAG_W-1:0] newTag;
        logic [`LSU_TAG_W-1:0] victimTag;
        logic                  victimDirty;
    } missReq_t;

endpackage

// ==== lsuTb.sv ====
// testbench for the load/store unit: random loads, stores and flushes against a shadow model
`include "lsu_macros.svh"

module lsuTb
    import lsuPkg::*;
();

    localparam int numReqs = 400;
    localparam int addrSpan = 512;
    localparam int initBound = `LSU_SETS * `LSU_WAYS + 5;
    localparam int flushBound = `LSU_SETS * `LSU_WAYS * 12;
    localparam int timeoutCycles = numReqs * 40 + 2 * flushBound + 500;

    logic clk;
    logic rst;
    lsuReq_t req;
    logic reqCredit;
    lsuRes_t res;
    logic flush;
    logic busy;
    memReq_t memReq;
    memRes_t memRes;

    integer seed;
    int credits;
    int cycles = 0;
    logic [`LSU_ID_W-1:0] nextId;
    logic [`LSU_DATA_W-1:0] shadow [addrSpan];
    logic [`LSU_ID_W-1:0] expIds [$];
    logic [`LSU_DATA_W-1:0] expData [$];
    logic [`LSU_ID_W-1:0] expId;
    logic [`LSU_DATA_W-1:0] expWord;

    lsuTop UUT (
        .clk(clk), .rst(rst),
        .req(req), .reqCredit(reqCredit),
        .res(res),
        .flush(flush), .busy(busy),
        .memReq(memReq), .memRes(memRes)
    );

    memModel backing (
        .clk(clk), .rst(rst),
        .memReq(memReq), .memRes(memRes)
    );

    always #5 clk = ~clk;

    task automatic abortRun(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic stopOnMismatch(input string name, input logic [`LSU_DATA_W-1:0] expected,
                                  input logic [`LSU_DATA_W-1:0] actual);
        abortRun($sformatf("FAIL time %0t %s expected %h actual %h",
                           $time, name, expected, actual));
    endtask

    // byte lanes with a set mask bit take the new data
    function automatic logic [`LSU_DATA_W-1:0] applyStore(input logic [`LSU_DATA_W-1:0] old,
                                                          input logic [`LSU_DATA_W-1:0] data,
                                                          input logic [`LSU_MASK_W-1:0] mask);
        logic [`LSU_DATA_W-1:0] lanes;
        lanes = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (old & ~lanes) | (data & lanes);
    endfunction

    task automatic waitBusyLow(input int limit, input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (busy) begin
            waited = waited + 1;
            assert (waited <= limit)
            else abortRun($sformatf("busy stayed high over %0d cycles after %s", limit, what));
            @(negedge clk);
        end
    endtask

    task automatic issueTraffic(input int count);
        int sent;
        int addr;
        logic [31:0] r;
        logic [`LSU_DATA_W-1:0] data;
        sent = 0;
        while (sent < count) begin
            @(posedge clk);
            #1;
            req = '0;
            // idle cycles now and then let credits build up
            if (credits > 0 && {$random(seed)} % 4 != 0) begin
                addr = {$random(seed)} % addrSpan;
                data = $random(seed);
                r = $random(seed);
                req.valid = 1'b1;
                req.id = nextId;
                req.addr = addr[`LSU_ADDR_W-1:0];
                if ({$random(seed)} % 10 < 6) begin
                    req.op = opLoad;
                    expIds.push_back(nextId);
                    expData.push_back(shadow[addr]);
                end else begin
                    req.op = opStore;
                    req.data = data;
                    req.mask = r[`LSU_MASK_W-1:0];
                    shadow[addr] = applyStore(shadow[addr], data, r[`LSU_MASK_W-1:0]);
                end
                nextId = nextId + 1'b1;
                credits = credits - 1;
                sent = sent + 1;
            end
        end
        @(posedge clk);
        #1;
        req = '0;
    endtask

    task automatic pulseFlush();
        @(posedge clk);
        #1;
        flush = 1'b1;
        @(negedge clk);
        assert (busy) else abortRun("busy did not rise with the flush pulse");
        @(posedge clk);
        #1;
        flush = 1'b0;
        waitBusyLow(flushBound, "flush");
    endtask

    // results and credits are sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (reqCredit) begin
                credits = credits + 1;
                assert (credits <= `LSU_QUEUE_DEPTH)
                else abortRun("credit pulses raised the credit count above the queue depth");
            end
            if (res.valid) begin
                assert (expIds.size() > 0)
                else abortRun("load result appeared with no load outstanding");
                expId = expIds.pop_front();
                expWord = expData.pop_front();
                assert (res.id === expId)
                else stopOnMismatch("res.id", {28'd0, expId}, {28'd0, res.id});
                assert (res.data === expWord) else stopOnMismatch("res.data", expWord, res.data);
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeoutCycles) begin
            abortRun($sformatf("timeout, run did not finish within %0d cycles", timeoutCycles));
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        req = '0;
        seed = 58;
        nextId = '0;
        credits = `LSU_QUEUE_DEPTH;
        for (int a = 0; a < addrSpan; a++) begin
            shadow[a] = a;
        end

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (busy) else abortRun("busy was low right after reset");
        assert (!res.valid) else abortRun("result valid right after reset");
        assert (!reqCredit) else abortRun("credit pulse right after reset");
        assert (memReq.cmd == memNone) else abortRun("memory command right after reset");
        waitBusyLow(initBound, "reset");

        issueTraffic(numReqs / 2);
        pulseFlush();
        issueTraffic(numReqs - numReqs / 2);

        // let every load return and every credit come back
        while (expIds.size() != 0 || credits != `LSU_QUEUE_DEPTH) begin
            @(negedge clk);
        end
        pulseFlush();

        // all dirty lines must have reached memory
        for (int a = 0; a < addrSpan; a++) begin
            assert (backing.words[a] === shadow[a])
            else stopOnMismatch($sformatf("memory word %0d", a), shadow[a], backing.words[a]);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== lsuTop.sv ====
// load/store unit top: request queue, lookup pipeline, miss/flush controller and cache arrays
`include "lsu_macros.svh"

module lsuTop
    import lsuPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  lsuReq_t req,
    output logic    reqCredit,
    output lsuRes_t res,
    input  logic    flush,
    output logic    busy,
    output memReq_t memReq,
    input  memRes_t memRes
);

    lsuReq_t queued;
    logic pop;
    logic hold;
    logic pipeIdle;
    logic missDone;
    missReq_t miss;

    // port A belongs to the pipeline, port B to the controller
    logic [`LSU_IDX_W-1:0] pipeTagIdx;
    logic [`LSU_IDX_W-1:0] ctrlTagIdx;
    tagSet_t pipeTagSet;
    tagSet_t ctrlTagSet;
    tagWrite_t pipeTagWr;
    tagWrite_t ctrlTagWr;
    logic [`LSU_WIDX_W-1:0] pipeDataAddr;
    logic [`LSU_WIDX_W-1:0] ctrlDataAddr;
    logic [`LSU_WAYS-1:0][`LSU_DATA_W-1:0] pipeData;
    logic [`LSU_WAYS-1:0][`LSU_DATA_W-1:0] ctrlData;
    dataWrite_t pipeDataWr;
    dataWrite_t ctrlDataWr;

    reqQueue queue (
        .clk(clk), .rst(rst),
        .inReq(req), .credit(reqCredit),
        .pop(pop), .outReq(queued)
    );

    lsuPipeline pipeline (
        .clk(clk), .rst(rst),
        .inReq(queued), .pop(pop), .hold(hold),
        .tagRdIdx(pipeTagIdx), .tagSet(pipeTagSet), .tagWr(pipeTagWr),
        .dataRdAddr(pipeDataAddr), .dataRdData(pipeData), .dataWr(pipeDataWr),
        .miss(miss), .missDone(missDone), .idle(pipeIdle), .res(res)
    );

    missFlushCtrl ctrl (
        .clk(clk), .rst(rst),
        .miss(miss), .missDone(missDone),
        .flush(flush), .pipeIdle(pipeIdle), .hold(hold), .busy(busy),
        .tagRdIdx(ctrlTagIdx), .tagSet(ctrlTagSet), .tagWr(ctrlTagWr),
        .dataRdAddr(ctrlDataAddr), .dataRdData(ctrlData), .dataWr(ctrlDataWr),
        .memReq(memReq), .memRes(memRes)
    );

    cacheTagTable tagTable (
        .clk(clk), .rst(rst),
        .rdIdxA(pipeTagIdx), .rdSetA(pipeTagSet),
        .rdIdxB(ctrlTagIdx), .rdSetB(ctrlTagSet),
        .pipeWr(pipeTagWr), .ctrlWr(ctrlTagWr)
    );

    cacheDataArray dataArray (
        .clk(clk),
        .rdAddrA(pipeDataAddr), .rdDataA(pipeData),
        .rdAddrB(ctrlDataAddr), .rdDataB(ctrlData),
        .pipeWr(pipeDataWr), .ctrlWr(ctrlDataWr)
    );

endmodule

// ==== lsu_macros.svh ====
// load/store unit parameters: widths, cache geometry and request queue depth
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// word address and data
`define LSU_ADDR_W 16
`define LSU_DATA_W 32
`define LSU_MASK_W (`LSU_DATA_W / 8)
`define LSU_ID_W 4

// cache geometry
`define LSU_LINE_WORDS 4
`define LSU_SETS 16
`define LSU_WAYS 2
`define LSU_QUEUE_DEPTH 4

// derived widths
`define LSU_OFF_W $clog2(`LSU_LINE_WORDS)
`define LSU_IDX_W $clog2(`LSU_SETS)
`define LSU_WAY_W $clog2(`LSU_WAYS)
`define LSU_TAG_W (`LSU_ADDR_W - `LSU_IDX_W - `LSU_OFF_W)
`define LSU_WIDX_W (`LSU_IDX_W + `LSU_OFF_W)
`define LSU_LINE_W (`LSU_ADDR_W - `LSU_OFF_W)

`endif

// ==== memModel.sv ====
// backing memory for the testbench, answers line fills and takes line write-backs
`include "lsu_macros.svh"

module memModel
    import lsuPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  memReq_t memReq,
    output memRes_t memRes
);

    logic [`LSU_DATA_W-1:0] words [2**`LSU_ADDR_W];
    logic [`LSU_LINE_W-1:0] fillLine;
    logic [`LSU_LINE_W-1:0] wbLine;
    logic [`LSU_OFF_W-1:0] fillIdx;
    logic [`LSU_OFF_W-1:0] wbIdx;
    logic fillActive;
    int waitCnt;
    integer seed;

    // every word starts out holding its own address
    initial begin
        seed = 58;
        for (int a = 0; a < 2**`LSU_ADDR_W; a++) begin
            words[a] = a;
        end
    end

    always @(posedge clk) begin
        memRes <= '0;
        if (rst) begin
            fillActive <= 1'b0;
            fillIdx <= '0;
            wbIdx <= '0;
            waitCnt <= 0;
        end else begin
            if (memReq.cmd == memFill) begin
                fillLine <= memReq.lineAddr;
                fillIdx <= '0;
                // first word reaches the controller 2 to 5 cycles after the command
                waitCnt <= 1 + ({$random(seed)} % 4);
                fillActive <= 1'b1;
            end else if (fillActive) begin
                if (waitCnt > 1) begin
                    waitCnt <= waitCnt - 1;
                end else begin
                    memRes <= '{rvalid: 1'b1, rdata: words[{fillLine, fillIdx}]};
                    fillIdx <= fillIdx + 1'b1;
                    if (&fillIdx) begin
                        fillActive <= 1'b0;
                    end
                end
            end
            // write data follows the command, one word per cycle
            if (memReq.cmd == memWriteback) begin
                wbLine <= memReq.lineAddr;
                wbIdx <= '0;
            end else if (memReq.wvalid) begin
                words[{wbLine, wbIdx}] <= memReq.wdata;
                wbIdx <= wbIdx + 1'b1;
            end
        end
    end

endmodule

// ==== missFlushCtrl.sv ====
// miss and flush controller: victim write-back, line fill, reset invalidation and flush scan
`include "lsu_macros.svh"

module missFlushCtrl
    import lsuPkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst,
    input  missReq_t                              miss,
    output logic                                  missDone,
    input  logic                                  flush,
    input  logic                                  pipeIdle,
    output logic                                  hold,
    output logic                                  busy,
    output logic [`LSU_IDX_W-1:0]                 tagRdIdx,
    input  tagSet_t                               tagSet,
    output tagWrite_t                             tagWr,
    output logic [`LSU_WIDX_W-1:0]                dataRdAddr,
    input  logic [`LSU_WAYS-1:0][`LSU_DATA_W-1:0] dataRdData,
    output dataWrite_t                            dataWr,
    output memReq_t                               memReq,
    input  memRes_t                               memRes
);

    ctrlState_e state;
    logic [`LSU_IDX_W+`LSU_WAY_W-1:0] scanIdx;
    logic [`LSU_IDX_W-1:0] scanSet;
    logic [`LSU_WAY_W-1:0] scanWay;
    logic scanRd;
    logic flushPending;
    logic [`LSU_OFF_W:0] wordCnt;
    logic [`LSU_IDX_W-1:0] curSet;
    logic [`LSU_WAY_W-1:0] curWay;
    logic [`LSU_TAG_W-1:0] curTag;
    logic [`LSU_TAG_W-1:0] victimTag;
    tagEntry_t scanEntry;
    logic wbLast;
    logic fillLast;
    logic scanLast;

    assign {scanSet, scanWay} = scanIdx;
    assign scanEntry = tagSet.way[scanWay];
    assign scanLast = &scanIdx;
    // write-back is one command cycle plus one cycle per word
    assign wbLast = (wordCnt == `LSU_LINE_WORDS);
    assign fillLast = (state == stFill) && memRes.rvalid && (wordCnt == `LSU_LINE_WORDS - 1);

    assign hold = flushPending || (state != stIdle);
    assign busy = flush || flushPending || state == stInit ||
                  state == stFlushScan || state == stFlushWb;
    assign tagRdIdx = scanSet;
    assign dataRdAddr = {curSet, wordCnt[`LSU_OFF_W-1:0]};

    always_comb begin
        memReq = '0;
        memReq.cmd = memNone;
        tagWr = '0;
        dataWr = '0;
        case (state)
            stInit: begin
                tagWr = '{valid: 1'b1, set: scanSet, way: scanWay, entry: '0};
            end
            stWriteback, stFlushWb: begin
                memReq.lineAddr = {victimTag, curSet};
                if (wordCnt == '0) begin
                    memReq.cmd = memWriteback;
                end else begin
                    // word read one cycle earlier
                    memReq.wvalid = 1'b1;
                    memReq.wdata = dataRdData[curWay];
                end
                if (state == stFlushWb && wbLast) begin
                    tagWr = '{valid: 1'b1, set: curSet, way: curWay, entry: '0};
                end
            end
            stFillReq: begin
                memReq.cmd = memFill;
                memReq.lineAddr = {curTag, curSet};
            end
            stFill: begin
                if (memRes.rvalid) begin
                    dataWr = '{valid: 1'b1, way: curWay, idx: {curSet, wordCnt[`LSU_OFF_W-1:0]},
                               data: memRes.rdata, mask: '1};
                end
                // new line lands valid and clean with its last word
                if (fillLast) begin
                    tagWr = '{valid: 1'b1, set: curSet, way: curWay,
                              entry: '{valid: 1'b1, dirty: 1'b0, tag: curTag}};
                end
            end
            stFlushScan: begin
                if (scanRd && !(scanEntry.valid && scanEntry.dirty)) begin
                    tagWr = '{valid: 1'b1, set: scanSet, way: scanWay, entry: '0};
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stInit;
            scanIdx <= '0;
            scanRd <= 1'b0;
            flushPending <= 1'b0;
            wordCnt <= '0;
            missDone <= 1'b0;
        end else begin
            missDone <= fillLast;
            if (flush) begin
                flushPending <= 1'b1;
            end
            case (state)
                // invalidate everything, nothing is written back
                stInit: begin
                    scanIdx <= scanIdx + 1'b1;
                    if (scanLast) begin
                        state <= stIdle;
                    end
                end
                stIdle: begin
                    wordCnt <= '0;
                    // miss is still raised during the missDone cycle
                    if (miss.valid && !missDone) begin
                        curSet <= miss.set;
                        curWay <= miss.way;
                        curTag <= miss.newTag;
                        victimTag <= miss.victimTag;
                        state <= miss.victimDirty ? stWriteback : stFillReq;
                    end else if (flushPending && pipeIdle) begin
                        flushPending <= flush;
                        scanIdx <= '0;
                        scanRd <= 1'b0;
                        state <= stFlushScan;
                    end
                end
                stWriteback: begin
                    wordCnt <= wordCnt + 1'b1;
                    if (wbLast) begin
                        wordCnt <= '0;
                        state <= stFillReq;
                    end
                end
                stFillReq: begin
                    state <= stFill;
                end
                stFill: begin
                    if (memRes.rvalid) begin
                        wordCnt <= wordCnt + 1'b1;
                    end
                    if (fillLast) begin
                        state <= stIdle;
                    end
                end
                // one cycle to read the tags, one to decide
                stFlushScan: begin
                    scanRd <= !scanRd;
                    if (scanRd) begin
                        if (scanEntry.valid && scanEntry.dirty) begin
                            curSet <= scanSet;
                            curWay <= scanWay;
                            victimTag <= scanEntry.tag;
                            wordCnt <= '0;
                            state <= stFlushWb;
                        end else begin
                            scanIdx <= scanIdx + 1'b1;
                            if (scanLast) begin
                                state <= stIdle;
                            end
                        end
                    end
                end
                stFlushWb: begin
                    wordCnt <= wordCnt + 1'b1;
                    if (wbLast) begin
                        scanIdx <= scanIdx + 1'b1;
                        state <= scanLast ? stIdle : stFlushScan;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // memory answers only the single outstanding fill
    assert property (@(posedge clk) disable iff (rst)
        memRes.rvalid |-> state == stFill);

endmodule

// ==== reqQueue.sv ====
// request FIFO in front of the pipeline, returns one credit per popped entry
`include "lsu_macros.svh"

module reqQueue
    import lsuPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  lsuReq_t inReq,
    output logic    credit,
    input  logic    pop,
    output lsuReq_t outReq
);

    localparam int ptrW = $clog2(`LSU_QUEUE_DEPTH);

    lsuReq_t entries [`LSU_QUEUE_DEPTH];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [ptrW:0] count;
    logic doPop;

    assign doPop = pop && (count != '0);

    always_ff @(posedge clk) begin
        if (inReq.valid) begin
            entries[wrPtr] <= inReq;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            credit <= 1'b0;
        end else begin
            if (inReq.valid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + {{ptrW{1'b0}}, inReq.valid} - {{ptrW{1'b0}}, doPop};
            // credit goes back one cycle after the pop
            credit <= doPop;
        end
    end

    always_comb begin
        outReq = entries[rdPtr];
        outReq.valid = (count != '0);
    end

    // the requester spends credits, so a full queue never sees a push
    assert property (@(posedge clk) disable iff (rst)
        inReq.valid |-> (count != (ptrW + 1)'(`LSU_QUEUE_DEPTH)));

endmodule
